//--- Bender.yml
package:
  name: aes_core

sources:
  - files:
      - hw/aes_pkg.sv
      - hw/aes_sub_word.sv
      - hw/aes_control_unit.sv
      - hw/aes_key_schedule.sv
      - hw/aes_state_datapath.sv
      - hw/aes_core.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/aes_core_checker.sv
      - sim/aes_tb.sv

//--- aes_core.f
+incdir+sim
hw/aes_pkg.sv
hw/aes_sub_word.sv
hw/aes_control_unit.sv
hw/aes_key_schedule.sv
hw/aes_state_datapath.sv
hw/aes_core.sv
sim/aes_core_checker.sv
sim/aes_tb.sv

//--- hw/aes_control_unit.sv
// AES round controller, sequences key update and column cycles per round
`timescale 1ns/10ps

module aes_control_unit #(
	parameter int ROUNDS = aes_pkg::NUM_ROUNDS
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	output aes_pkg::aes_ctrl_t ctrl,
	output logic               done
);

	// ==============================
	// FSM encoding
	// ==============================
	typedef enum logic [2:0] {
		IDLE,
		ROUND_KEY,
		COL0,
		COL1,
		COL2,
		COL3,
		READY
	} state_e;

	state_e     state;
	state_e     next_state;
	logic [3:0] rd_count;
	logic [3:0] round_num;
	logic       last_round;

	// State flops
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Completed rounds, bumped on leaving each ROUND_KEY
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_count <= 4'd0;
		else if (state == IDLE)
			rd_count <= 4'd0;
		else if (state == ROUND_KEY)
			rd_count <= rd_count + 4'd1;
	end

	// Round in progress, counter lags by one during ROUND_KEY
	assign round_num = (state == ROUND_KEY) ? rd_count + 4'd1 : rd_count;
	assign last_round = (round_num == 4'(ROUNDS));

	// ==============================
	// Next state
	// ==============================
	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
				if (start)
					next_state = ROUND_KEY;
			ROUND_KEY:
				next_state = COL0;
			COL0:
				next_state = COL1;
			COL1:
				next_state = COL2;
			COL2:
				next_state = COL3;
			// Leave after the last column of the final round
			COL3:
				next_state = last_round ? READY : ROUND_KEY;
			READY:
				next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
	end

	// ==============================
	// Control bundle decode
	// ==============================
	always_comb
	begin
		ctrl = '0;
		ctrl.sbox_src = aes_pkg::SBOX_COL0;
		// Start only counts while idle
		ctrl.load = start && (state == IDLE);
		ctrl.round = round_num;
		ctrl.last_round = last_round;
		case (state)
			// g function on key word 3, ShiftRows on the whole state
			ROUND_KEY:
			begin
				ctrl.sbox_src = aes_pkg::SBOX_KEY;
				ctrl.key_en = 4'b0001;
				ctrl.shift_en = 1'b1;
			end
			// Word 0 already fresh from ROUND_KEY
			COL0:
			begin
				ctrl.sbox_src = aes_pkg::SBOX_COL0;
				ctrl.col_en = 4'b0001;
			end
			COL1:
			begin
				ctrl.sbox_src = aes_pkg::SBOX_COL1;
				ctrl.col_en = 4'b0010;
				ctrl.key_en = 4'b0010;
			end
			COL2:
			begin
				ctrl.sbox_src = aes_pkg::SBOX_COL2;
				ctrl.col_en = 4'b0100;
				ctrl.key_en = 4'b0100;
			end
			COL3:
			begin
				ctrl.sbox_src = aes_pkg::SBOX_COL3;
				ctrl.col_en = 4'b1000;
				ctrl.key_en = 4'b1000;
			end
			default:
			begin
				ctrl.col_en = 4'b0000;
			end
		endcase
	end

	// One-cycle completion strobe
	assign done = (state == READY);

endmodule

//--- hw/aes_core.sv
// Iterative AES-128 encryption core, one column per cycle
`timescale 1ns/10ps

module aes_core #(
	parameter int ROUNDS = aes_pkg::NUM_ROUNDS
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            start,
	input  aes_pkg::block_t block_in,
	input  aes_pkg::block_t key_in,
	output logic            done,
	output aes_pkg::block_t block_out
);

	aes_pkg::aes_ctrl_t ctrl;
	aes_pkg::block_t    round_key;
	aes_pkg::word_t     sub_in;
	aes_pkg::word_t     sub_out;

	// ==============================
	// Controller
	// ==============================
	aes_control_unit #(
		.ROUNDS (ROUNDS)
	) u_ctrl (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.ctrl  (ctrl),
		.done  (done)
	);

	// Key words, fed by the shared S-boxes during ROUND_KEY
	aes_key_schedule u_key (
		.clk       (clk),
		.rst_n     (rst_n),
		.key_in    (key_in),
		.ctrl      (ctrl),
		.sub_out   (sub_out),
		.round_key (round_key)
	);

	// State columns, output is the result register
	aes_state_datapath u_dp (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.block_in  (block_in),
		.round_key (round_key),
		.sub_out   (sub_out),
		.sub_in    (sub_in),
		.state     (block_out)
	);

	// Single S-box bank shared by columns and key
	aes_sub_word u_sbox (
		.in  (sub_in),
		.out (sub_out)
	);

endmodule

//--- hw/aes_key_schedule.sv
// AES-128 on-the-fly key schedule, one key word updated per cycle
`timescale 1ns/10ps

module aes_key_schedule (
	input  logic               clk,
	input  logic               rst_n,
	input  aes_pkg::block_t    key_in,
	input  aes_pkg::aes_ctrl_t ctrl,
	input  aes_pkg::word_t     sub_out,
	output aes_pkg::block_t    round_key
);

	aes_pkg::block_t key_q;
	aes_pkg::block_t key_nxt;
	aes_pkg::word_t  g_word;
	logic [7:0]      rcon;

	// ==============================
	// Round constant
	// ==============================
	// RCON_INIT doubled round-1 times
	always_comb
	begin
		rcon = aes_pkg::RCON_INIT;
		for (int i = 2; i < 16; i++)
		begin
			if (i <= int'(ctrl.round))
				rcon = aes_pkg::xtime(rcon);
		end
	end

	// S-boxes see word 3 unrotated, so rotate the result here
	assign g_word = {sub_out[1] ^ rcon, sub_out[2], sub_out[3], sub_out[0]};

	// ==============================
	// Word update chain
	// ==============================
	always_comb
	begin
		key_nxt[0] = key_q[0] ^ g_word;
		// Left neighbour is already the new word
		for (int c = 1; c < aes_pkg::NUM_WORDS; c++)
			key_nxt[c] = key_q[c] ^ key_q[c-1];
	end

	// Word being written this cycle shows its new value
	always_comb
	begin
		for (int c = 0; c < aes_pkg::NUM_WORDS; c++)
			round_key[c] = ctrl.key_en[c] ? key_nxt[c] : key_q[c];
		// Host key straight through for the initial AddRoundKey
		if (ctrl.load)
			round_key = key_in;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			key_q <= '0;
		else if (ctrl.load)
			key_q <= key_in;
		else
		begin
			for (int c = 0; c < aes_pkg::NUM_WORDS; c++)
				if (ctrl.key_en[c])
					key_q[c] <= key_nxt[c];
		end
	end

endmodule

//--- hw/aes_pkg.sv
// AES-128 shared types, per-cycle control bundle and GF(2^8) helper
package aes_pkg;

	// ==============================
	// Round and word constants
	// ==============================
	localparam int NUM_ROUNDS = 10;
	localparam int NUM_WORDS = 4;
	// First round constant, doubled once per round
	localparam logic [7:0] RCON_INIT = 8'h01;
	// S-box affine offset
	localparam logic [7:0] SBOX_AFFINE_C = 8'h63;
	// Reduction of x^8 by the AES field polynomial
	localparam logic [7:0] GF_POLY = 8'h1b;

	// ==============================
	// Data types
	// ==============================
	// One column, row 0 is the most significant byte
	typedef logic [0:3][7:0] word_t;
	// Four columns, column 0 is the most significant word
	typedef word_t [0:3] block_t;

	// What feeds the shared S-box bank
	typedef enum logic [2:0] {
		SBOX_COL0 = 3'd0,
		SBOX_COL1 = 3'd1,
		SBOX_COL2 = 3'd2,
		SBOX_COL3 = 3'd3,
		SBOX_KEY  = 3'd4
	} sbox_src_e;

	// One cycle of commands from the round controller
	typedef struct packed {
		logic       load;
		sbox_src_e  sbox_src;
		logic [3:0] col_en;
		logic       shift_en;
		logic [3:0] key_en;
		logic       last_round;
		logic [3:0] round;
	} aes_ctrl_t;

	// Multiply by x in GF(2^8)
	function automatic logic [7:0] xtime(input logic [7:0] a);
		return {a[6:0], 1'b0} ^ (a[7] ? GF_POLY : 8'h00);
	endfunction

endpackage

//--- hw/aes_state_datapath.sv
// AES state register with ShiftRows, MixColumns and AddRoundKey per column
`timescale 1ns/10ps

module aes_state_datapath (
	input  logic               clk,
	input  logic               rst_n,
	input  aes_pkg::aes_ctrl_t ctrl,
	input  aes_pkg::block_t    block_in,
	input  aes_pkg::block_t    round_key,
	input  aes_pkg::word_t     sub_out,
	output aes_pkg::word_t     sub_in,
	output aes_pkg::block_t    state
);

	aes_pkg::word_t col_val;

	// ==============================
	// Round transforms
	// ==============================
	// Row r moves left by r columns
	function automatic aes_pkg::block_t shift_rows(input aes_pkg::block_t s);
		aes_pkg::block_t b;
		for (int c = 0; c < aes_pkg::NUM_WORDS; c++)
			for (int r = 0; r < 4; r++)
				b[c][r] = s[(c + r) % 4][r];
		return b;
	endfunction

	// b_r = 2*a_r ^ 3*a_r+1 ^ a_r+2 ^ a_r+3
	function automatic aes_pkg::word_t mix_column(input aes_pkg::word_t a);
		aes_pkg::word_t b;
		for (int r = 0; r < 4; r++)
			b[r] = aes_pkg::xtime(a[r]) ^ aes_pkg::xtime(a[(r + 1) % 4])
				^ a[(r + 1) % 4] ^ a[(r + 2) % 4] ^ a[(r + 3) % 4];
		return b;
	endfunction

	// S-box feed, a state column or the last key word
	always_comb
	begin
		if (ctrl.sbox_src == aes_pkg::SBOX_KEY)
			sub_in = round_key[3];
		else
			sub_in = state[ctrl.sbox_src[1:0]];
	end

	// Final round skips MixColumns
	assign col_val = ctrl.last_round ? sub_out : mix_column(sub_out);

	// ==============================
	// State register
	// ==============================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= '0;
		// Initial AddRoundKey on load
		else if (ctrl.load)
			state <= block_in ^ round_key;
		else if (ctrl.shift_en)
			state <= shift_rows(state);
		else
		begin
			for (int c = 0; c < aes_pkg::NUM_WORDS; c++)
				if (ctrl.col_en[c])
					state[c] <= col_val ^ round_key[c];
		end
	end

endmodule

//--- hw/aes_sub_word.sv
// AES S-box bank for one 32-bit word, inverse plus affine map per byte
`timescale 1ns/10ps

module aes_sub_word (
	input  aes_pkg::word_t in,
	output aes_pkg::word_t out
);

	// ==============================
	// GF(2^8) arithmetic
	// ==============================
	// Shift-and-add multiply
	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] acc;
		logic [7:0] p;
		acc = 8'h00;
		p = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				acc = acc ^ p;
			p = aes_pkg::xtime(p);
		end
		return acc;
	endfunction

	// Inverse as a^254, product of a^2 through a^128
	// Zero maps to zero, as the S-box needs
	function automatic logic [7:0] gf_inv(input logic [7:0] a);
		logic [7:0] sq;
		logic [7:0] acc;
		sq = a;
		acc = 8'h01;
		for (int i = 1; i < 8; i++)
		begin
			sq = gf_mul(sq, sq);
			acc = gf_mul(acc, sq);
		end
		return acc;
	endfunction

	// Affine step, XOR of four left rotations plus the constant
	function automatic logic [7:0] affine(input logic [7:0] b);
		return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
			^ {b[3:0], b[7:4]} ^ aes_pkg::SBOX_AFFINE_C;
	endfunction

	// ==============================
	// Four byte lanes in parallel
	// ==============================
	always_comb
	begin
		for (int r = 0; r < aes_pkg::NUM_WORDS; r++)
			out[r] = affine(gf_inv(in[r]));
	end

endmodule

//--- sim/aes_core_checker.sv
// Assertions on the AES round controller strobes and control bundle
`timescale 1ns/10ps

module aes_core_checker (
	input logic               clk,
	input logic               rst_n,
	input aes_pkg::aes_ctrl_t ctrl,
	input logic               done
);

	// Count of failed assertions, read by the testbench at the end
	int fail_count = 0;

	// ==============================
	// Strobes
	// ==============================
	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
	else
	begin
		$error("done was high for two cycles in a row");
		fail_count++;
	end

	// Load only from idle, never while a result strobe is pending
	load_not_in_done: assert property (@(posedge clk) disable iff (!rst_n) ctrl.load |-> !done)
	else
	begin
		$error("load was decoded while done was high");
		fail_count++;
	end

	// ==============================
	// Control bundle
	// ==============================
	// Column cycles write one column and at most the matching key word
	col_key_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		(|ctrl.col_en) |-> ($onehot(ctrl.col_en)
		&& (ctrl.key_en == 4'b0000 || ctrl.key_en == ctrl.col_en)))
	else
	begin
		$error("column cycle with a bad column or key word enable");
		fail_count++;
	end

	// Key update cycle touches only key word 0
	shift_key_word0: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.shift_en |-> (ctrl.key_en == 4'b0001 && ctrl.col_en == 4'b0000))
	else
	begin
		$error("ShiftRows cycle with wrong enables");
		fail_count++;
	end

	// Result is held, nothing may write while done is high
	quiet_on_done: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (ctrl.col_en == 4'b0000 && ctrl.key_en == 4'b0000
		&& !ctrl.shift_en && !ctrl.load))
	else
	begin
		$error("an enable was high while done was high");
		fail_count++;
	end

endmodule

//--- sim/aes_ref_model.svh
// AES-128 reference model, byte-oriented encryption as laid out in FIPS-197
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// S-box table, filled once before the first encryption
logic [7:0] sbox_tab [0:255];

// Shift-and-add product in GF(2^8)
function automatic logic [7:0] gf_mult(input logic [7:0] a, input logic [7:0] b);
	logic [7:0] p;
	logic [7:0] x;
	p = 8'h00;
	x = a;
	for (int i = 0; i < 8; i++)
	begin
		if (b[i])
			p = p ^ x;
		x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
	end
	return p;
endfunction

// Inverse by search, then the bitwise affine formula
task automatic fill_sbox_table();
	logic [7:0] inv;
	logic [7:0] s;
	logic [7:0] c;
	c = 8'h63;
	for (int x = 0; x < 256; x++)
	begin
		inv = 8'h00;
		for (int y = 1; y < 256; y++)
			if (gf_mult(8'(x), 8'(y)) == 8'h01)
				inv = 8'(y);
		for (int i = 0; i < 8; i++)
			s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
				^ inv[(i + 7) % 8] ^ c[i];
		sbox_tab[x] = s;
	end
endtask

// Byte i sits in bits 127-8i down, column i/4, row i%4
function automatic logic [127:0] encrypt_block(input logic [127:0] pt, input logic [127:0] key,
	input int rounds);
	logic [7:0]   s [0:15];
	logic [7:0]   k [0:15];
	logic [7:0]   t [0:15];
	logic [7:0]   rc;
	logic [127:0] res;
	for (int i = 0; i < 16; i++)
	begin
		k[i] = key[127 - 8 * i -: 8];
		s[i] = pt[127 - 8 * i -: 8] ^ k[i];
	end
	rc = 8'h01;
	for (int rnd = 1; rnd <= rounds; rnd++)
	begin
		// Next round key from RotWord, SubWord and Rcon
		k[0] = k[0] ^ sbox_tab[k[13]] ^ rc;
		k[1] = k[1] ^ sbox_tab[k[14]];
		k[2] = k[2] ^ sbox_tab[k[15]];
		k[3] = k[3] ^ sbox_tab[k[12]];
		for (int i = 4; i < 16; i++)
			k[i] = k[i] ^ k[i - 4];
		rc = gf_mult(rc, 8'h02);
		// SubBytes and ShiftRows together
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				t[4 * c + r] = sbox_tab[s[4 * ((c + r) % 4) + r]];
		// MixColumns, skipped in the final round
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				if (rnd == rounds)
					s[4 * c + r] = t[4 * c + r] ^ k[4 * c + r];
				else
					s[4 * c + r] = gf_mult(t[4 * c + r], 8'h02)
						^ gf_mult(t[4 * c + (r + 1) % 4], 8'h03)
						^ t[4 * c + (r + 2) % 4] ^ t[4 * c + (r + 3) % 4] ^ k[4 * c + r];
	end
	for (int i = 0; i < 16; i++)
		res[127 - 8 * i -: 8] = s[i];
	return res;
endfunction

`endif

//--- sim/aes_tb.sv
// Testbench for the iterative AES-128 core, random vectors against a model
`timescale 1ns/10ps

module aes_tb;

	localparam int ROUNDS = aes_pkg::NUM_ROUNDS;
	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DLY = 2;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_RANDOM = 200;
	// Random runs plus FIPS, busy, hold, aborted and post-reset runs
	localparam int NUM_OPS = NUM_RANDOM + 5;
	// Accepting edge counts as the first, done in the cycle after the last column
	localparam int LATENCY = ROUNDS * 5 + 1;
	localparam int WATCHDOG_CYCLES = (NUM_OPS + 4) * (ROUNDS * 5 + 4);

	logic            clk;
	logic            rst_n;
	logic            start;
	aes_pkg::block_t block_in;
	aes_pkg::block_t key_in;
	logic            done;
	aes_pkg::block_t block_out;
	aes_pkg::block_t result;
	aes_pkg::block_t blk;
	aes_pkg::block_t key;

	`include "aes_ref_model.svh"

	aes_core #(
		.ROUNDS (ROUNDS)
	) UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.block_in  (block_in),
		.key_in    (key_in),
		.done      (done),
		.block_out (block_out)
	);

	bind aes_control_unit aes_core_checker u_chk (
		.clk   (clk),
		.rst_n (rst_n),
		.ctrl  (ctrl),
		.done  (done)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==============================
	// Reporting and compare tasks
	// ==============================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_block(input string name, input aes_pkg::block_t got,
		input aes_pkg::block_t exp);
		if (got !== exp)
			abort_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
	endtask

	function automatic aes_pkg::block_t random_block();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	// ==============================
	// Stimulus tasks
	// ==============================
	// One encryption, optional second start at edge inject_at while busy
	task automatic run_op(input aes_pkg::block_t b, input aes_pkg::block_t k,
		input int inject_at, output aes_pkg::block_t res);
		int edges;
		edges = 0;
		@(posedge clk);
		#DRIVE_DLY;
		block_in = b;
		key_in = k;
		start = 1'b1;
		do
		begin
			@(posedge clk);
			edges++;
			if (edges == 1 || (inject_at > 1 && edges == inject_at + 1))
			begin
				#DRIVE_DLY;
				start = 1'b0;
			end
			else if (inject_at > 1 && edges == inject_at)
			begin
				#DRIVE_DLY;
				block_in = random_block();
				key_in = random_block();
				start = 1'b1;
			end
			if (edges > 2 * LATENCY)
				abort_run("done never arrived after an accepted start");
			@(negedge clk);
		end while (!done);
		check_count("done latency", edges, LATENCY);
		res = block_out;
		@(negedge clk);
		check_bit("done", done, 1'b0);
	endtask

	// Result register must not move while the inputs change
	task automatic hold_check(input aes_pkg::block_t exp);
		repeat (20)
		begin
			@(posedge clk);
			#DRIVE_DLY;
			block_in = random_block();
			key_in = random_block();
			@(negedge clk);
			check_block("block_out", block_out, exp);
			check_bit("done", done, 1'b0);
		end
	endtask

	// Reset in the middle of a run
	task automatic reset_mid_run();
		@(posedge clk);
		#DRIVE_DLY;
		block_in = random_block();
		key_in = random_block();
		start = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;
		start = 1'b0;
		repeat (17) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b0;
		@(negedge clk);
		check_block("block_out", block_out, '0);
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		// FSM back in idle, the aborted run never completes
		repeat (LATENCY)
		begin
			@(negedge clk);
			check_bit("done", done, 1'b0);
		end
	endtask

	// Watchdog sized from the number of runs
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("Watchdog timeout, the test did not finish in time");
	end

	// ==============================
	// Main sequence
	// ==============================
	initial
	begin
		rst_n = 1'b0;
		start = 1'b0;
		block_in = '0;
		key_in = '0;
		void'($urandom(32'h3240));
		fill_sbox_table();
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;

		// FIPS-197 appendix C.1 vector
		blk = 128'h00112233445566778899aabbccddeeff;
		key = 128'h000102030405060708090a0b0c0d0e0f;
		check_block("model ciphertext", encrypt_block(blk, key, ROUNDS),
			128'h69c4e0d86a7b0430d8cdb78070b4c55a);
		run_op(blk, key, 0, result);
		check_block("block_out", result, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);

		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			blk = random_block();
			key = random_block();
			run_op(blk, key, 0, result);
			check_block("block_out", result, encrypt_block(blk, key, ROUNDS));
		end

		// Second start while busy is dropped
		blk = random_block();
		key = random_block();
		run_op(blk, key, 20, result);
		check_block("block_out", result, encrypt_block(blk, key, ROUNDS));

		blk = random_block();
		key = random_block();
		run_op(blk, key, 0, result);
		check_block("block_out", result, encrypt_block(blk, key, ROUNDS));
		hold_check(result);

		reset_mid_run();
		blk = random_block();
		key = random_block();
		run_op(blk, key, 0, result);
		check_block("block_out", result, encrypt_block(blk, key, ROUNDS));

		repeat (2) @(posedge clk);
		if (UUT.u_ctrl.u_chk.fail_count == 0)
		begin
			$display("No errors");
			$finish;
		end
		else
			abort_run("Bound controller assertions reported failures");
	end

endmodule
